// File: hdl/rv32Pkg.sv
`default_nettype none

package rv32Pkg;

	typedef logic [31:0] word_t;
	typedef logic [8:0] pc_t;
	typedef logic [4:0] regIdx_t;
	typedef logic [1:0] memSize_t;

	// access size codes, same as funct3[1:0] of loads and stores
	localparam memSize_t sizeByte = 2'd0;
	localparam memSize_t sizeHalf = 2'd1;
	localparam memSize_t sizeWord = 2'd2;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOp_t;

	typedef enum logic [2:0] {
		immI,
		immS,
		immB,
		immU,
		immJ
	} immFmt_t;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbPcPlus4
	} wbSrc_t;

	typedef enum logic [1:0] {
		seqIdle,
		seqFetch,
		seqExec,
		seqMemWait
	} seqState_t;

endpackage

`default_nettype wire

// File: hdl/instMem.sv
`timescale 1ns/1ps
`default_nettype none

module instMem import rv32Pkg::*; #(
	parameter int InstWords = 128
) (
	input wire logic clk,
	input wire logic enb,
	input wire logic wen,
	input wire logic [6:0] waddr,
	input wire word_t wdata,
	input wire pc_t raddr,
	output word_t rdata
);

	word_t mem [InstWords];

	always_ff @(posedge clk) begin
		if (wen)
			mem[waddr] <= wdata;
		// word index of the byte pc
		rdata <= mem[raddr[8:2]];
	end

	// program loading only while the core is halted
	assert property (@(posedge clk) !(wen && enb));

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import rv32Pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic we,
	input wire regIdx_t rs1,
	input wire regIdx_t rs2,
	input wire regIdx_t rd,
	input wire word_t wd,
	output word_t rd1,
	output word_t rd2
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= wd;
		end
	end

	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

	// one register write per instruction
	assert property (@(posedge clk) disable iff (rst) we |=> !we);

endmodule

`default_nettype wire

// File: hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import rv32Pkg::*; (
	input wire word_t inst,
	output word_t imm,
	output aluOp_t aluOp,
	output logic aSelPc,
	output logic bSelImm,
	output logic regWrite,
	output logic isLoad,
	output logic isStore,
	output logic isBranch,
	output logic isJump,
	output logic loadUnsigned,
	output memSize_t memSize,
	output wbSrc_t wbSrc,
	output logic [2:0] brFunct
);

	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opReg = 7'b0110011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	immFmt_t immFmt;
	aluOp_t arithOp;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign memSize = funct3[1:0];
	assign loadUnsigned = funct3[2];
	assign brFunct = funct3;

	// funct7 bit 5 picks SUB only for register ops, SRA for both
	always_comb begin
		case (funct3)
			3'b000: arithOp = (opcode == opReg && inst[30]) ? aluSub : aluAdd;
			3'b001: arithOp = aluSll;
			3'b010: arithOp = aluSlt;
			3'b011: arithOp = aluSltu;
			3'b100: arithOp = aluXor;
			3'b101: arithOp = inst[30] ? aluSra : aluSrl;
			3'b110: arithOp = aluOr;
			default: arithOp = aluAnd;
		endcase
	end

	always_comb begin
		aluOp = aluAdd;
		immFmt = immI;
		wbSrc = wbAlu;
		{aSelPc, bSelImm, regWrite} = 3'b000;
		{isLoad, isStore, isBranch, isJump} = 4'b0000;
		case (opcode)
			opLui: {aluOp, immFmt, bSelImm, regWrite} = {aluPassB, immU, 2'b11};
			opAuipc: {immFmt, aSelPc, bSelImm, regWrite} = {immU, 3'b111};
			opJal: begin
				{immFmt, aSelPc, bSelImm, regWrite, isJump} = {immJ, 4'b1111};
				wbSrc = wbPcPlus4;
			end
			opJalr: begin
				{bSelImm, regWrite, isJump} = 3'b111;
				wbSrc = wbPcPlus4;
			end
			opBranch: {immFmt, aSelPc, bSelImm, isBranch} = {immB, 3'b111};
			opLoad: begin
				{bSelImm, regWrite, isLoad} = 3'b111;
				wbSrc = wbMem;
			end
			opStore: {immFmt, bSelImm, isStore} = {immS, 2'b11};
			opImm: {aluOp, bSelImm, regWrite} = {arithOp, 2'b11};
			opReg: {aluOp, regWrite} = {arithOp, 1'b1};
			default: ;
		endcase
	end

	always_comb begin
		case (immFmt)
			immS: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			immB: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			immU: imm = {inst[31:12], 12'b0};
			immJ: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default: imm = {{20{inst[31]}}, inst[31:20]};
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv32Pkg::*; (
	input wire word_t a,
	input wire word_t b,
	input wire aluOp_t op,
	input wire logic [2:0] brFunct,
	input wire word_t rs1Val,
	input wire word_t rs2Val,
	output word_t result,
	output logic brTaken
);

	always_comb begin
		case (op)
			aluSub: result = a - b;
			aluSll: result = a << b[4:0];
			aluSlt: result = {31'b0, $signed(a) < $signed(b)};
			aluSltu: result = {31'b0, a < b};
			aluXor: result = a ^ b;
			aluSrl: result = a >> b[4:0];
			aluSra: result = $signed(a) >>> b[4:0];
			aluOr: result = a | b;
			aluAnd: result = a & b;
			aluPassB: result = b;
			default: result = a + b;
		endcase
	end

	// branch compare works on the register values, not the operands
	always_comb begin
		case (brFunct)
			3'b000: brTaken = rs1Val == rs2Val;
			3'b001: brTaken = rs1Val != rs2Val;
			3'b100: brTaken = $signed(rs1Val) < $signed(rs2Val);
			3'b101: brTaken = $signed(rs1Val) >= $signed(rs2Val);
			3'b110: brTaken = rs1Val < rs2Val;
			3'b111: brTaken = rs1Val >= rs2Val;
			default: brTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem import rv32Pkg::*; #(
	parameter int DataWords = 64
) (
	input wire logic clk,
	input wire logic we,
	input wire word_t addr,
	input wire memSize_t size,
	input wire logic loadUnsigned,
	input wire word_t wdata,
	output word_t rdata
);

	localparam int AddrW = $clog2(DataWords);

	word_t mem [DataWords];
	logic [AddrW-1:0] idx;
	word_t rdWord;
	logic [7:0] byteVal;
	logic [15:0] halfVal;

	// upper address bits ignored, so accesses wrap
	assign idx = addr[AddrW+1:2];

	always_ff @(posedge clk) begin
		if (we) begin
			case (size)
				sizeByte: mem[idx][8*addr[1:0] +: 8] <= wdata[7:0];
				sizeHalf: mem[idx][16*addr[1] +: 16] <= wdata[15:0];
				default: mem[idx] <= wdata;
			endcase
		end
	end

	assign rdWord = mem[idx];
	assign byteVal = rdWord[8*addr[1:0] +: 8];
	assign halfVal = rdWord[16*addr[1] +: 16];

	always_comb begin
		case (size)
			sizeByte: rdata = {{24{byteVal[7] & ~loadUnsigned}}, byteVal};
			sizeHalf: rdata = {{16{halfVal[15] & ~loadUnsigned}}, halfVal};
			default: rdata = rdWord;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/accessTimer.sv
`timescale 1ns/1ps
`default_nettype none

module accessTimer #(
	parameter int MemLatency = 3
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	output logic done
);

	localparam int CntW = (MemLatency > 1) ? $clog2(MemLatency) : 1;

	logic [CntW-1:0] count;
	logic running;

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			count <= '0;
		end else if (start) begin
			running <= 1'b1;
			count <= CntW'(MemLatency - 1);
		end else if (running) begin
			if (count == '0)
				running <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	assign done = running && count == '0;

	// sequencer must wait for done before the next access
	assert property (@(posedge clk) disable iff (rst) !(start && running));

endmodule

`default_nettype wire

// File: hdl/coreSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module coreSequencer import rv32Pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic enb,
	input wire logic isMem,
	input wire logic timerDone,
	output logic timerStart,
	output logic pcAdvance,
	output logic commit,
	output logic memWrite,
	output seqState_t state
);

	seqState_t nextState;
	logic memDone;

	assign memDone = state == seqMemWait && timerDone;

	always_comb begin
		nextState = state;
		case (state)
			seqIdle: if (enb) nextState = seqFetch;
			seqFetch: nextState = seqExec;
			seqExec: begin
				if (isMem)
					nextState = seqMemWait;
				else
					nextState = enb ? seqFetch : seqIdle;
			end
			default: if (timerDone) nextState = enb ? seqFetch : seqIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= seqIdle;
		else
			state <= nextState;
	end

	assign timerStart = state == seqExec && isMem;
	assign commit = (state == seqExec && !isMem) || memDone;
	assign pcAdvance = commit;
	assign memWrite = memDone;

	// a commit always ends the instruction
	assert property (@(posedge clk) disable iff (rst)
		commit |=> state inside {seqFetch, seqIdle});

endmodule

`default_nettype wire

// File: hdl/rv32Core.sv
`timescale 1ns/1ps
`default_nettype none

module rv32Core import rv32Pkg::*; #(
	parameter int InstWords = 128,
	parameter int DataWords = 64,
	parameter int MemLatency = 3
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic enb,
	input wire logic instWen,
	input wire logic [6:0] instAddr,
	input wire word_t instData,
	output logic wbValid,
	output regIdx_t wbRd,
	output word_t wbData
);

	// addi x0, x0, 0
	localparam word_t NopInst = 32'h0000_0013;

	pc_t pc, pcPlus4;
	word_t instWord, inst, imm, rd1, rd2, aluA, aluB, aluResult, memRdata, wbValue;
	aluOp_t aluOp;
	wbSrc_t wbSrc;
	memSize_t memSize;
	seqState_t seqState;
	logic [2:0] brFunct;
	logic aSelPc, bSelImm, regWrite, isLoad, isStore, isBranch, isJump, loadUnsigned;
	logic brTaken, timerStart, timerDone, pcAdvance, commit, memWrite, regWe;

	instMem #(.InstWords(InstWords)) uInstMem (
		.clk(clk), .enb(enb), .wen(instWen), .waddr(instAddr), .wdata(instData),
		.raddr(pc), .rdata(instWord)
	);

	// decode only what was fetched, idle and fetch see a nop
	assign inst = (seqState == seqExec || seqState == seqMemWait) ? instWord : NopInst;

	decoder uDecoder (
		.inst(inst), .imm(imm), .aluOp(aluOp), .aSelPc(aSelPc), .bSelImm(bSelImm),
		.regWrite(regWrite), .isLoad(isLoad), .isStore(isStore), .isBranch(isBranch),
		.isJump(isJump), .loadUnsigned(loadUnsigned), .memSize(memSize), .wbSrc(wbSrc),
		.brFunct(brFunct)
	);

	regFile uRegFile (
		.clk(clk), .rst(rst), .we(regWe), .rs1(inst[19:15]), .rs2(inst[24:20]),
		.rd(inst[11:7]), .wd(wbValue), .rd1(rd1), .rd2(rd2)
	);

	assign aluA = aSelPc ? {23'b0, pc} : rd1;
	assign aluB = bSelImm ? imm : rd2;

	alu uAlu (
		.a(aluA), .b(aluB), .op(aluOp), .brFunct(brFunct), .rs1Val(rd1), .rs2Val(rd2),
		.result(aluResult), .brTaken(brTaken)
	);

	dataMem #(.DataWords(DataWords)) uDataMem (
		.clk(clk), .we(memWrite && isStore), .addr(aluResult), .size(memSize),
		.loadUnsigned(loadUnsigned), .wdata(rd2), .rdata(memRdata)
	);

	accessTimer #(.MemLatency(MemLatency)) uTimer (
		.clk(clk), .rst(rst), .start(timerStart), .done(timerDone)
	);

	coreSequencer uSeq (
		.clk(clk), .rst(rst), .enb(enb), .isMem(isLoad || isStore), .timerDone(timerDone),
		.timerStart(timerStart), .pcAdvance(pcAdvance), .commit(commit),
		.memWrite(memWrite), .state(seqState)
	);

	assign pcPlus4 = pc + pc_t'(4);

	// jump targets are word aligned by dropping the low bits
	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (pcAdvance)
			pc <= (isJump || (isBranch && brTaken)) ? {aluResult[8:2], 2'b00} : pcPlus4;
	end

	always_comb begin
		case (wbSrc)
			wbMem: wbValue = memRdata;
			wbPcPlus4: wbValue = {23'b0, pcPlus4};
			default: wbValue = aluResult;
		endcase
	end

	assign regWe = commit && regWrite;
	assign wbValid = regWe && inst[11:7] != '0;
	assign wbRd = inst[11:7];
	assign wbData = wbValue;

endmodule

`default_nettype wire

// File: tests/rv32CoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rv32CoreTb import rv32Pkg::*; ;

	localparam int MemLatency = 3;
	localparam int ProgLen = 101;
	localparam int ClkPeriod = 4;
	localparam int WatchdogNs = (8 + ProgLen + ProgLen * (2 + MemLatency) * 2) * ClkPeriod;

	logic clk, rst, enb, instWen;
	logic [6:0] instAddr;
	word_t instData;
	logic wbValid;
	regIdx_t wbRd;
	word_t wbData;

	integer seed;
	word_t prog [128];
	word_t xr [32];
	logic [7:0] dm [256];
	word_t mPc;
	int stAddr [128];
	int stSize [128];
	int nSt, nExp, gotCount, cycle, lastWbCycle, expCycles, startCycle;
	regIdx_t expRd [128];
	word_t expVal [128];
	logic expTight [128];
	logic prevAlu;
	int valueErrors, timingErrors, seqErrors;

	rv32Core #(.InstWords(128), .DataWords(64), .MemLatency(MemLatency)) UUT (
		.clk(clk), .rst(rst), .enb(enb), .instWen(instWen), .instAddr(instAddr),
		.instData(instData), .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic int rnd(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic word_t encI(input word_t imm, input word_t rs1, input word_t f3,
			input word_t rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t encS(input word_t imm, input word_t rs2, input word_t f3);
		return {imm[11:5], rs2[4:0], 5'd0, f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t encB(input word_t imm, input word_t rs2, input word_t rs1,
			input word_t f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t encJ(input word_t imm, input word_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic word_t aluCalc(input logic [2:0] f3, input logic alt, input word_t a,
			input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// reference execution of one instruction at mPc
	task automatic execute(input word_t in);
		word_t a, b, immI, immS, immB, immJ, res, nextPc;
		logic [2:0] f3;
		regIdx_t rd;
		logic wr, mem;
		int addr;
		f3 = in[14:12];
		rd = in[11:7];
		a = xr[in[19:15]];
		b = xr[in[24:20]];
		immI = {{20{in[31]}}, in[31:20]};
		immS = {{20{in[31]}}, in[31:25], in[11:7]};
		immB = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
		immJ = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
		nextPc = mPc + 4;
		res = '0;
		wr = 1'b1;
		mem = 1'b0;
		case (in[6:0])
			7'b0110111: res = {in[31:12], 12'b0};
			7'b0010111: res = mPc + {in[31:12], 12'b0};
			7'b1101111: begin
				res = mPc + 4;
				nextPc = mPc + immJ;
			end
			7'b1100111: begin
				res = mPc + 4;
				nextPc = (a + immI) & ~32'd3;
			end
			7'b1100011: begin
				wr = 1'b0;
				if (taken(f3, a, b))
					nextPc = mPc + immB;
			end
			7'b0000011: begin
				mem = 1'b1;
				addr = (a + immI) & 255;
				case (f3[1:0])
					2'd0: res = {{24{dm[addr][7] & ~f3[2]}}, dm[addr]};
					2'd1: res = {{16{dm[addr + 1][7] & ~f3[2]}}, dm[addr + 1], dm[addr]};
					default: res = {dm[addr + 3], dm[addr + 2], dm[addr + 1], dm[addr]};
				endcase
			end
			7'b0100011: begin
				mem = 1'b1;
				wr = 1'b0;
				addr = (a + immS) & 255;
				for (int k = 0; k < (1 << f3[1:0]); k++)
					dm[addr + k] = b[8*k +: 8];
				stAddr[nSt] = addr;
				stSize[nSt] = f3[1:0];
				nSt++;
			end
			7'b0010011: res = aluCalc(f3, f3 == 3'd5 && in[30], a, immI);
			default: res = aluCalc(f3, in[30], a, b);
		endcase
		if (wr && rd != '0) begin
			xr[rd] = res;
			expRd[nExp] = rd;
			expVal[nExp] = res;
			expTight[nExp] = prevAlu && !mem;
			nExp++;
		end
		prevAlu = wr && rd != '0 && !mem;
		expCycles += mem ? 2 + MemLatency : 2;
		mPc = nextPc;
	endtask

	// forward control flow only, so the model can run alongside generation
	task automatic buildProgram();
		int kind, rd, rs1, rs2, f3, sz, lsz, j, tgt, imm;
		word_t in;
		word_t uImm;
		for (int i = 0; i < ProgLen - 1; i++) begin
			kind = rnd(10);
			rd = rnd(32);
			rs1 = rnd(32);
			rs2 = rnd(32);
			f3 = rnd(8);
			tgt = i + 1 + rnd(6);
			if (tgt > ProgLen - 1)
				tgt = ProgLen - 1;
			if ((kind == 6 || kind == 7) && nSt == 0)
				kind = 5;
			case (kind)
				0, 1: begin
					imm = (f3 == 0 || f3 == 5) ? rnd(2) << 10 : 0;
					in = encI(imm | rs2, rs1, f3, rd, 7'b0110011);
				end
				2, 3: begin
					if (f3 == 1)
						imm = rnd(32);
					else if (f3 == 5)
						imm = rnd(32) | (rnd(2) << 10);
					else
						imm = rnd(4096) - 2048;
					in = encI(imm, rs1, f3, rd, 7'b0010011);
				end
				4: begin
					uImm = $random(seed);
					in = {uImm[31:12], 5'(rd), rnd(2) ? 7'b0110111 : 7'b0010111};
				end
				5: begin
					sz = rnd(3);
					in = encS(rnd(256) & ~((1 << sz) - 1), rs2, sz);
				end
				6, 7: begin
					// reload bytes that an executed store has written
					j = rnd(nSt);
					lsz = rnd(stSize[j] + 1);
					imm = stAddr[j] + (rnd(1 << stSize[j]) & ~((1 << lsz) - 1));
					f3 = lsz + ((lsz < 2 && rnd(2) == 1) ? 4 : 0);
					in = encI(imm, 0, f3, rd, 7'b0000011);
				end
				8: begin
					f3 = rnd(6);
					if (f3 >= 2)
						f3 += 2;
					in = encB((tgt - i) * 4, rs2, rs1, f3);
				end
				default: in = rnd(2) ? encJ((tgt - i) * 4, rd) : encI(tgt * 4, 0, 0, rd, 7'b1100111);
			endcase
			prog[i] = in;
			if (mPc == i * 4)
				execute(in);
		end
		// final jal x0 to itself
		prog[ProgLen - 1] = encJ(0, 0);
	endtask

	always @(negedge clk) begin
		if (wbValid) begin
			if (!enb) begin
				$display("writeback seen before the core was enabled at %0t", $time);
				seqErrors++;
			end else if (gotCount >= nExp) begin
				$display("unexpected extra writeback to x%0d at %0t", wbRd, $time);
				seqErrors++;
			end else begin
				if (wbRd != expRd[gotCount] || wbData != expVal[gotCount]) begin
					$display("** Error at %0t: writeback %0d got x%0d=%h, expected x%0d=%h",
						$time, gotCount, wbRd, wbData, expRd[gotCount], expVal[gotCount]);
					valueErrors++;
				end
				if (expTight[gotCount] && cycle - lastWbCycle != 2) begin
					$display("** Error at %0t: writeback %0d after %0d cycles, expected 2",
						$time, gotCount, cycle - lastWbCycle);
					timingErrors++;
				end
				gotCount++;
				lastWbCycle = cycle;
			end
		end
	end

	initial begin
		#(WatchdogNs);
		$display("watchdog expired, core stopped retiring (%0d of %0d writebacks)",
			gotCount, nExp);
		$display("test failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		enb = 1'b0;
		instWen = 1'b0;
		instAddr = '0;
		instData = '0;
		seed = 32'hf921;
		cycle = 0;
		mPc = '0;
		prevAlu = 1'b0;
		{nSt, nExp, gotCount, lastWbCycle, expCycles} = '0;
		{valueErrors, timingErrors, seqErrors} = '0;
		for (int r = 0; r < 32; r++)
			xr[r] = '0;
		buildProgram();
		repeat (8) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < ProgLen; i++) begin
			@(negedge clk);
			instWen = 1'b1;
			instAddr = 7'(i);
			instData = prog[i];
		end
		@(negedge clk);
		instWen = 1'b0;
		repeat (4) @(negedge clk);
		enb = 1'b1;
		startCycle = cycle;
		wait (gotCount == nExp);
		// stay on until the self loop is reached to catch stray writebacks
		while (cycle < startCycle + expCycles + 10)
			@(negedge clk);
		$display("errors: %0d value, %0d timing, %0d sequence", valueErrors, timingErrors, seqErrors);
		if (valueErrors + timingErrors + seqErrors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
hdl/rv32Pkg.sv
hdl/instMem.sv
hdl/regFile.sv
hdl/decoder.sv
hdl/alu.sv
hdl/dataMem.sv
hdl/accessTimer.sv
hdl/coreSequencer.sv
hdl/rv32Core.sv
tests/rv32CoreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rv32CoreTb \
	-f verilog.f -o rv32CoreTb

output=$(./obj_dir/rv32CoreTb)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi
